// File: source/riscv_macros.svh
`ifndef RISCV_MACROS_SVH
`define RISCV_MACROS_SVH

// Data and instruction width
`define XLEN 32

// Word address width of the instruction and data memories
`define IMEM_AWIDTH 10

// First fetch address after reset or while idle
`define RESET_PC 32'h0000_0000

// CSR written by CSRRW and shown on the csr port
`define CSR_TOHOST 12'h51E

`define NUM_REGS 32

`endif

// File: source/riscv_pkg.sv
`include "riscv_macros.svh"

package riscv_pkg;

  typedef logic [`XLEN-1:0] word_t;
  typedef logic [`XLEN-1:0] inst_t;
  typedef logic [`XLEN-1:0] pc_t;       // Byte address
  typedef logic [4:0] reg_addr_t;
  typedef logic [`IMEM_AWIDTH-1:0] imem_addr_t;  // Word address

  // ALU operations, PASS_B forwards the second operand (LUI)
  typedef enum logic [3:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    SLL,
    SRL,
    SRA,
    SLT,
    SLTU,
    PASS_B
  } alu_op_e;

  typedef enum logic [1:0] {
    WB_ALU,
    WB_MEM,
    WB_PC4
  } wb_sel_e;

  typedef enum logic [1:0] {
    BR_NONE,
    BR_EQ,
    BR_NE,
    BR_JAL
  } br_kind_e;

endpackage

// File: source/pipe_if.sv
`timescale 1ns/1ns

// Decoded instruction bundle held in the ID/EX register
interface pipe_if;
  import riscv_pkg::*;

  logic      valid;
  pc_t       pc;
  word_t     rs1_data;
  word_t     rs2_data;
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  reg_addr_t rd_addr;
  word_t     imm;
  alu_op_e   alu_op;
  logic      b_is_imm;   // ALU operand b is imm instead of rs2
  logic      mem_read;
  logic      mem_write;
  wb_sel_e   wb_sel;
  logic      reg_we;
  br_kind_e  br_kind;
  logic      csr_we;

  modport src(
    output valid, pc, rs1_data, rs2_data, rs1_addr, rs2_addr, rd_addr, imm,
           alu_op, b_is_imm, mem_read, mem_write, wb_sel, reg_we, br_kind, csr_we
  );

  modport dst(
    input valid, pc, rs1_data, rs2_data, rs1_addr, rs2_addr, rd_addr, imm,
          alu_op, b_is_imm, mem_read, mem_write, wb_sel, reg_we, br_kind, csr_we
  );

endinterface

// File: source/fetch_stage.sv
`timescale 1ns/1ns

`include "riscv_macros.svh"

module fetch_stage (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   run,
  input  logic                   prog_we,
  input  riscv_pkg::imem_addr_t  prog_addr,
  input  riscv_pkg::inst_t       prog_data,
  input  logic                   redirect,
  input  riscv_pkg::pc_t         redirect_pc,
  output riscv_pkg::inst_t       fetch_inst,
  output riscv_pkg::pc_t         fetch_pc
);
  import riscv_pkg::*;

  localparam inst_t NOP = 32'h0000_0013;  // addi x0, x0, 0

  pc_t        pc;
  imem_addr_t pc_word;
  inst_t      imem [0:(1 << `IMEM_AWIDTH)-1];
  inst_t      imem_q;
  logic       flush_q;  // Word in imem_q is on a dead path

  assign pc_word = pc[`IMEM_AWIDTH+1:2];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc      <= `RESET_PC;
      flush_q <= 1'b1;
    end else begin
      if (!run)
        pc <= `RESET_PC;  // Idle, hold at start
      else if (redirect)
        pc <= redirect_pc;
      else
        pc <= pc + 32'd4;
      flush_q <= redirect | ~run;
    end
  end

  // Synchronous read, program writes only while idle
  always_ff @(posedge clk) begin
    if (prog_we && !run)
      imem[prog_addr] <= prog_data;
    imem_q   <= imem[pc_word];
    fetch_pc <= pc;
  end

  assign fetch_inst = flush_q ? NOP : imem_q;

endmodule

// File: source/register_file.sv
`timescale 1ns/1ns

`include "riscv_macros.svh"

module register_file (
  input  logic                  clk,
  input  logic                  arst_n,
  input  riscv_pkg::reg_addr_t  rs1_addr,
  input  riscv_pkg::reg_addr_t  rs2_addr,
  input  logic                  wb_we,
  input  riscv_pkg::reg_addr_t  wb_addr,
  input  riscv_pkg::word_t      wb_data,
  output riscv_pkg::word_t      rs1_data,
  output riscv_pkg::word_t      rs2_data
);
  import riscv_pkg::*;

  word_t regs [`NUM_REGS];

  // x0 reads zero, a write in the same cycle passes straight through
  function automatic word_t read_port(reg_addr_t addr);
    if (addr == '0)
      return '0;
    if (wb_we && wb_addr == addr)
      return wb_data;
    return regs[addr];
  endfunction

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `NUM_REGS; i++)
        regs[i] <= '0;
    end else if (wb_we && wb_addr != '0) begin
      regs[wb_addr] <= wb_data;
    end
  end

  always_comb begin
    rs1_data = read_port(rs1_addr);
    rs2_data = read_port(rs2_addr);
  end

endmodule

// File: source/decode_stage.sv
`timescale 1ns/1ns

`include "riscv_macros.svh"

module decode_stage (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  run,
  input  logic                  redirect,
  input  riscv_pkg::inst_t      fetch_inst,
  input  riscv_pkg::pc_t        fetch_pc,
  input  riscv_pkg::word_t      rs1_data,
  input  riscv_pkg::word_t      rs2_data,
  output riscv_pkg::reg_addr_t  rs1_addr,
  output riscv_pkg::reg_addr_t  rs2_addr,
  pipe_if.src                   ex
);
  import riscv_pkg::*;

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_addr_t  rd_addr;
  word_t      imm_i, imm_s, imm_b, imm_j, imm_u;

  logic     legal;
  logic     alt_ok;     // funct7 allowed for this funct3
  alu_op_e  dec_alu_op;
  word_t    dec_imm;
  logic     dec_b_is_imm;
  logic     dec_mem_read, dec_mem_write;
  wb_sel_e  dec_wb_sel;
  logic     dec_reg_we;
  br_kind_e dec_br_kind;
  logic     dec_csr_we;

  assign opcode   = fetch_inst[6:0];
  assign funct3   = fetch_inst[14:12];
  assign funct7   = fetch_inst[31:25];
  assign rd_addr  = fetch_inst[11:7];
  assign rs1_addr = fetch_inst[19:15];
  assign rs2_addr = fetch_inst[24:20];

  assign imm_i = {{20{fetch_inst[31]}}, fetch_inst[31:20]};
  assign imm_s = {{20{fetch_inst[31]}}, fetch_inst[31:25], fetch_inst[11:7]};
  assign imm_b = {{19{fetch_inst[31]}}, fetch_inst[31], fetch_inst[7],
                  fetch_inst[30:25], fetch_inst[11:8], 1'b0};
  assign imm_j = {{11{fetch_inst[31]}}, fetch_inst[31], fetch_inst[19:12],
                  fetch_inst[20], fetch_inst[30:21], 1'b0};
  assign imm_u = {fetch_inst[31:12], 12'b0};

  // Only SUB and SRA/SRAI take the alternate funct7
  assign alt_ok = (funct7 == 7'b0000000) ||
                  (funct7 == 7'b0100000 && (funct3 == 3'b101 ||
                   (funct3 == 3'b000 && opcode == OPC_OP)));

  always_comb begin
    legal         = 1'b0;
    dec_alu_op    = ADD;
    dec_imm       = imm_i;
    dec_b_is_imm  = 1'b0;
    dec_mem_read  = 1'b0;
    dec_mem_write = 1'b0;
    dec_wb_sel    = WB_ALU;
    dec_reg_we    = 1'b0;
    dec_br_kind   = BR_NONE;
    dec_csr_we    = 1'b0;

    // Shared ALU function for register and immediate forms
    case (funct3)
      3'b000:  dec_alu_op = (opcode == OPC_OP && funct7[5]) ? SUB : ADD;
      3'b001:  dec_alu_op = SLL;
      3'b010:  dec_alu_op = SLT;
      3'b011:  dec_alu_op = SLTU;
      3'b100:  dec_alu_op = XOR;
      3'b101:  dec_alu_op = funct7[5] ? SRA : SRL;
      3'b110:  dec_alu_op = OR;
      default: dec_alu_op = AND;
    endcase

    case (opcode)
      OPC_OP: begin
        legal      = alt_ok;
        dec_reg_we = 1'b1;
      end
      OPC_OP_IMM: begin
        legal        = (funct3 == 3'b001 || funct3 == 3'b101) ? alt_ok : 1'b1;
        dec_b_is_imm = 1'b1;
        dec_reg_we   = 1'b1;
      end
      OPC_LUI: begin
        legal        = 1'b1;
        dec_alu_op   = PASS_B;
        dec_imm      = imm_u;
        dec_b_is_imm = 1'b1;
        dec_reg_we   = 1'b1;
      end
      OPC_LOAD: begin
        legal        = (funct3 == 3'b010);  // LW only
        dec_alu_op   = ADD;
        dec_b_is_imm = 1'b1;
        dec_mem_read = 1'b1;
        dec_wb_sel   = WB_MEM;
        dec_reg_we   = 1'b1;
      end
      OPC_STORE: begin
        legal         = (funct3 == 3'b010);  // SW only
        dec_alu_op    = ADD;
        dec_imm       = imm_s;
        dec_b_is_imm  = 1'b1;
        dec_mem_write = 1'b1;
      end
      OPC_BRANCH: begin
        legal       = (funct3 == 3'b000 || funct3 == 3'b001);
        dec_imm     = imm_b;
        dec_br_kind = funct3[0] ? BR_NE : BR_EQ;
      end
      OPC_JAL: begin
        legal       = 1'b1;
        dec_imm     = imm_j;
        dec_wb_sel  = WB_PC4;
        dec_reg_we  = 1'b1;
        dec_br_kind = BR_JAL;
      end
      OPC_SYSTEM: begin
        // CSRRW to the tohost CSR, old value goes to rd
        legal      = (funct3 == 3'b001) && (fetch_inst[31:20] == `CSR_TOHOST);
        dec_reg_we = 1'b1;
        dec_csr_we = 1'b1;
      end
      default: legal = 1'b0;
    endcase

    if (rd_addr == '0)
      dec_reg_we = 1'b0;
  end

  // ID/EX register, control part
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex.valid     <= 1'b0;
      ex.reg_we    <= 1'b0;
      ex.mem_read  <= 1'b0;
      ex.mem_write <= 1'b0;
      ex.csr_we    <= 1'b0;
      ex.br_kind   <= BR_NONE;
      ex.wb_sel    <= WB_ALU;
    end else begin
      ex.valid     <= legal & run & ~redirect;  // Kill wrong path and idle words
      ex.reg_we    <= dec_reg_we;
      ex.mem_read  <= dec_mem_read;
      ex.mem_write <= dec_mem_write;
      ex.csr_we    <= dec_csr_we;
      ex.br_kind   <= dec_br_kind;
      ex.wb_sel    <= dec_wb_sel;
    end
  end

  always_ff @(posedge clk) begin
    ex.pc       <= fetch_pc;
    ex.rs1_data <= rs1_data;
    ex.rs2_data <= rs2_data;
    ex.rs1_addr <= rs1_addr;
    ex.rs2_addr <= rs2_addr;
    ex.rd_addr  <= rd_addr;
    ex.imm      <= dec_imm;
    ex.alu_op   <= dec_alu_op;
    ex.b_is_imm <= dec_b_is_imm;
  end

endmodule

// File: source/execute_stage.sv
`timescale 1ns/1ns

`include "riscv_macros.svh"

module execute_stage (
  input  logic                  clk,
  input  logic                  arst_n,
  pipe_if.dst                   ex,
  output logic                  redirect,
  output riscv_pkg::pc_t        redirect_pc,
  output logic                  wb_we,
  output riscv_pkg::reg_addr_t  wb_addr,
  output riscv_pkg::word_t      wb_data,
  output riscv_pkg::word_t      csr,
  output logic                  csr_we
);
  import riscv_pkg::*;

  word_t      op_a, op_b;     // Forwarded rs1 and rs2
  word_t      alu_b;
  word_t      alu_out;
  word_t      ex_result;
  logic       taken;
  imem_addr_t dmem_addr;
  word_t      dmem [0:(1 << `IMEM_AWIDTH)-1];
  word_t      dmem_q;
  word_t      wb_result;
  wb_sel_e    wb_sel_q;

  // Writeback bypass into EX
  always_comb begin
    op_a = ex.rs1_data;
    op_b = ex.rs2_data;
    if (wb_we && wb_addr != '0 && wb_addr == ex.rs1_addr)
      op_a = wb_data;
    if (wb_we && wb_addr != '0 && wb_addr == ex.rs2_addr)
      op_b = wb_data;
  end

  assign alu_b = ex.b_is_imm ? ex.imm : op_b;

  always_comb begin
    case (ex.alu_op)
      ADD:     alu_out = op_a + alu_b;
      SUB:     alu_out = op_a - alu_b;
      AND:     alu_out = op_a & alu_b;
      OR:      alu_out = op_a | alu_b;
      XOR:     alu_out = op_a ^ alu_b;
      SLL:     alu_out = op_a << alu_b[4:0];
      SRL:     alu_out = op_a >> alu_b[4:0];
      SRA:     alu_out = $signed(op_a) >>> alu_b[4:0];
      SLT:     alu_out = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
      SLTU:    alu_out = {{(`XLEN-1){1'b0}}, op_a < alu_b};
      default: alu_out = alu_b;  // PASS_B
    endcase
  end

  always_comb begin
    case (ex.br_kind)
      BR_EQ:   taken = (op_a == op_b);
      BR_NE:   taken = (op_a != op_b);
      BR_JAL:  taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  assign redirect    = ex.valid & taken;
  assign redirect_pc = ex.pc + ex.imm;

  // CSRRW returns the value before this write
  always_comb begin
    if (ex.csr_we)
      ex_result = csr;
    else if (ex.wb_sel == WB_PC4)
      ex_result = ex.pc + 32'd4;
    else
      ex_result = alu_out;
  end

  assign dmem_addr = alu_out[`IMEM_AWIDTH+1:2];

  always_ff @(posedge clk) begin
    if (ex.valid && ex.mem_write)
      dmem[dmem_addr] <= op_b;
    if (ex.mem_read)
      dmem_q <= dmem[dmem_addr];  // Ready in the writeback cycle
    wb_addr   <= ex.rd_addr;
    wb_result <= ex_result;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_we    <= 1'b0;
      wb_sel_q <= WB_ALU;
      csr      <= '0;
      csr_we   <= 1'b0;
    end else begin
      wb_we    <= ex.valid & ex.reg_we;
      wb_sel_q <= ex.wb_sel;
      csr_we   <= ex.valid & ex.csr_we;
      if (ex.valid && ex.csr_we)
        csr <= op_a;
    end
  end

  // Load data joins the writeback path here
  assign wb_data = (wb_sel_q == WB_MEM) ? dmem_q : wb_result;

endmodule

// File: source/riscv_core.sv
`timescale 1ns/1ns

module riscv_core (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   run,
  input  logic                   prog_we,
  input  riscv_pkg::imem_addr_t  prog_addr,
  input  riscv_pkg::inst_t       prog_data,
  output riscv_pkg::word_t       csr,
  output logic                   csr_we
);
  import riscv_pkg::*;

  inst_t     fetch_inst;
  pc_t       fetch_pc;
  logic      redirect;
  pc_t       redirect_pc;
  reg_addr_t rs1_addr, rs2_addr;
  word_t     rs1_data, rs2_data;
  logic      wb_we;
  reg_addr_t wb_addr;
  word_t     wb_data;

  pipe_if id_ex();  // ID/EX bundle

  fetch_stage u_fetch (
    .clk        (clk),
    .arst_n     (arst_n),
    .run        (run),
    .prog_we    (prog_we),
    .prog_addr  (prog_addr),
    .prog_data  (prog_data),
    .redirect   (redirect),
    .redirect_pc(redirect_pc),
    .fetch_inst (fetch_inst),
    .fetch_pc   (fetch_pc)
  );

  register_file u_regs (
    .clk     (clk),
    .arst_n  (arst_n),
    .rs1_addr(rs1_addr),
    .rs2_addr(rs2_addr),
    .wb_we   (wb_we),
    .wb_addr (wb_addr),
    .wb_data (wb_data),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data)
  );

  decode_stage u_decode (
    .clk       (clk),
    .arst_n    (arst_n),
    .run       (run),
    .redirect  (redirect),
    .fetch_inst(fetch_inst),
    .fetch_pc  (fetch_pc),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .rs1_addr  (rs1_addr),
    .rs2_addr  (rs2_addr),
    .ex        (id_ex.src)
  );

  execute_stage u_execute (
    .clk        (clk),
    .arst_n     (arst_n),
    .ex         (id_ex.dst),
    .redirect   (redirect),     // Also flushes IF and ID
    .redirect_pc(redirect_pc),
    .wb_we      (wb_we),
    .wb_addr    (wb_addr),
    .wb_data    (wb_data),
    .csr        (csr),
    .csr_we     (csr_we)
  );

endmodule

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int PERIOD       = 20,
  parameter int RESET_CYCLES = 3
) (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Release on a falling edge, away from the active edge
  initial begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
  end

endmodule

// File: verification/riscv_core_chk.sv
`timescale 1ns/1ns

module riscv_core_chk (
  input logic                  clk,
  input logic                  arst_n,
  input logic                  csr_we,
  input logic                  redirect,
  input logic                  ex_valid,
  input riscv_pkg::reg_addr_t  rs1_addr,
  input riscv_pkg::reg_addr_t  rs2_addr,
  input riscv_pkg::word_t      op_a,
  input riscv_pkg::word_t      op_b
);

  int unsigned fail_count = 0;  // Failed assertions so far

  csr_we_in_reset: assert property (@(posedge clk) !arst_n |-> !csr_we)
    else begin
      $error("csr_we high while in reset");
      fail_count++;
    end

  // x0 must read as zero in EX, through the register file and the bypass
  x0_read_rs1: assert property (@(posedge clk) disable iff (!arst_n)
    (ex_valid && rs1_addr == '0) |-> op_a == '0)
    else begin
      $error("nonzero value read from x0 on rs1");
      fail_count++;
    end

  x0_read_rs2: assert property (@(posedge clk) disable iff (!arst_n)
    (ex_valid && rs2_addr == '0) |-> op_b == '0)
    else begin
      $error("nonzero value read from x0 on rs2");
      fail_count++;
    end

  redirect_single: assert property (@(posedge clk) disable iff (!arst_n)
    redirect |=> !redirect)
    else begin
      $error("redirect high in two consecutive cycles");
      fail_count++;
    end

endmodule

bind execute_stage riscv_core_chk u_chk (
  .clk     (clk),
  .arst_n  (arst_n),
  .csr_we  (csr_we),
  .redirect(redirect),
  .ex_valid(ex.valid),
  .rs1_addr(ex.rs1_addr),
  .rs2_addr(ex.rs2_addr),
  .op_a    (op_a),
  .op_b    (op_b)
);

// File: verification/riscv_core_tb.sv
`timescale 1ns/1ns

`include "riscv_macros.svh"

module riscv_core_tb;
  import riscv_pkg::*;

  localparam int MAX_ROWS = 48;
  localparam int TIMEOUT  = 200;   // Cycles allowed per wait
  localparam int JAL_PC   = 8;     // JAL sits after one LUI/ADDI pair

  // Row kinds
  localparam int K_REG = 0;
  localparam int K_IMM = 1;
  localparam int K_MEM = 2;
  localparam int K_BEQ = 3;
  localparam int K_BNE = 4;
  localparam int K_JAL = 5;

  // ALU operations of the table
  localparam int OP_ADD  = 0;
  localparam int OP_SUB  = 1;
  localparam int OP_AND  = 2;
  localparam int OP_OR   = 3;
  localparam int OP_XOR  = 4;
  localparam int OP_SLL  = 5;
  localparam int OP_SRL  = 6;
  localparam int OP_SRA  = 7;
  localparam int OP_SLT  = 8;
  localparam int OP_SLTU = 9;

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  logic       clk;
  logic       arst_n;
  logic       run;
  logic       prog_we;
  imem_addr_t prog_addr;
  inst_t      prog_data;
  word_t      csr;
  logic       csr_we;

  // Stimulus table
  int    row_kind [0:MAX_ROWS-1];
  int    row_op   [0:MAX_ROWS-1];
  word_t row_a    [0:MAX_ROWS-1];
  word_t row_b    [0:MAX_ROWS-1];
  word_t row_exp  [0:MAX_ROWS-1];
  int    num_rows;

  inst_t prog [0:15];  // Assembled program
  int    prog_len;
  int    seed;

  tb_clock_gen #(.PERIOD(20), .RESET_CYCLES(3)) u_clk (
    .clk   (clk),
    .arst_n(arst_n)
  );

  riscv_core DUT (
    .clk      (clk),
    .arst_n   (arst_n),
    .run      (run),
    .prog_we  (prog_we),
    .prog_addr(prog_addr),
    .prog_data(prog_data),
    .csr      (csr),
    .csr_we   (csr_we)
  );

  task automatic check_value(input string what, input word_t got, input word_t expected);
    if (got !== expected) begin
      $display("FAIL at %0t ns: %s is %h, expected %h", $time, what, got, expected);
      $display("TEST FAIL");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  function automatic word_t sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  // RV32I result of one ALU operation
  function automatic word_t ref_alu(input int op, input word_t a, input word_t b);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_SLL:  return a << b[4:0];
      OP_SRL:  return a >> b[4:0];
      OP_SRA:  return $signed(a) >>> b[4:0];
      OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      default: return (a < b) ? 32'd1 : 32'd0;
    endcase
  endfunction

  function automatic word_t expected_for(input int kind, input int op,
                                         input word_t a, input word_t b);
    case (kind)
      K_REG:   return ref_alu(op, a, b);
      K_IMM:   return ref_alu(op, a, sext12(b[11:0]));
      K_MEM:   return a;
      K_BEQ:   return (a == b) ? a : a + 32'd1;  // Taken skips the increment
      K_BNE:   return (a != b) ? a : a + 32'd1;
      default: return JAL_PC + 4;
    endcase
  endfunction

  function automatic logic [2:0] funct3_of(input int op);
    case (op)
      OP_ADD, OP_SUB: return 3'b000;
      OP_SLL:         return 3'b001;
      OP_SLT:         return 3'b010;
      OP_SLTU:        return 3'b011;
      OP_XOR:         return 3'b100;
      OP_SRL, OP_SRA: return 3'b101;
      OP_OR:          return 3'b110;
      default:        return 3'b111;
    endcase
  endfunction

  function automatic logic [6:0] alt7(input int op);
    return (op == OP_SUB || op == OP_SRA) ? 7'b0100000 : 7'b0000000;
  endfunction

  function automatic inst_t r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                   input logic [4:0] rs1, input logic [2:0] f3,
                                   input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic inst_t i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                   input logic [2:0] f3, input logic [4:0] rd,
                                   input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic inst_t s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                   input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic inst_t b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                   input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic inst_t j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic inst_t csrrw(input logic [4:0] rs1);
    return i_type(`CSR_TOHOST, rs1, 3'b001, 5'd0, 7'b1110011);
  endfunction

  task automatic emit(input inst_t w);
    prog[prog_len] = w;
    prog_len++;
  endtask

  // LUI plus ADDI, upper part rounded for the signed low half
  task automatic load_const(input logic [4:0] rd, input word_t val);
    word_t hi;
    hi = val + 32'h800;
    emit({hi[31:12], rd, 7'b0110111});
    emit(i_type(val[11:0], rd, 3'b000, rd, OPC_OP_IMM));
  endtask

  task automatic assemble(input int kind, input int op, input word_t a, input word_t b);
    logic [11:0] imm;
    prog_len = 0;
    case (kind)
      K_REG: begin
        load_const(5'd1, a);
        load_const(5'd2, b);
        emit(r_type(alt7(op), 5'd2, 5'd1, funct3_of(op), 5'd3));
        emit(csrrw(5'd3));  // Result forwarded straight in
      end
      K_IMM: begin
        load_const(5'd1, a);
        if (op == OP_SLL || op == OP_SRL || op == OP_SRA)
          imm = {alt7(op), b[4:0]};
        else
          imm = b[11:0];
        emit(i_type(imm, 5'd1, funct3_of(op), 5'd3, OPC_OP_IMM));
        emit(csrrw(5'd3));
      end
      K_MEM: begin
        load_const(5'd1, a);
        load_const(5'd2, b & 32'h0000_0FF0);
        emit(s_type(12'd4, 5'd1, 5'd2));
        emit(i_type(12'd4, 5'd2, 3'b010, 5'd4, 7'b0000011));
        emit(r_type(7'd0, 5'd0, 5'd4, 3'b000, 5'd5));  // Load data used at once
        emit(csrrw(5'd5));
      end
      K_BEQ, K_BNE: begin
        load_const(5'd1, a);
        load_const(5'd2, b);
        emit(b_type(13'd8, 5'd2, 5'd1, (kind == K_BNE) ? 3'b001 : 3'b000));
        emit(i_type(12'd1, 5'd1, 3'b000, 5'd1, OPC_OP_IMM));
        emit(csrrw(5'd1));
      end
      default: begin
        load_const(5'd6, a);
        emit(j_type(21'd8, 5'd6));
        emit(i_type(12'd1, 5'd0, 3'b000, 5'd6, OPC_OP_IMM));  // Skipped
        emit(csrrw(5'd6));
      end
    endcase
    emit(j_type(21'd0, 5'd0));  // Park on a self loop
  endtask

  task automatic add_row(input int kind, input int op, input word_t a, input word_t b);
    row_kind[num_rows] = kind;
    row_op[num_rows]   = op;
    row_a[num_rows]    = a;
    row_b[num_rows]    = b;
    row_exp[num_rows]  = expected_for(kind, op, a, b);
    num_rows++;
  endtask

  task automatic build_table();
    int    n;
    int    r_kind;
    int    r_op;
    word_t ra;
    word_t rb;
    num_rows = 0;
    add_row(K_REG, OP_ADD,  32'h7FFF_FFFF, 32'h0000_0001);
    add_row(K_REG, OP_SUB,  32'd5,         32'd7);
    add_row(K_REG, OP_AND,  32'hF0F0_1234, 32'h0FF0_FFFF);
    add_row(K_REG, OP_OR,   32'h1200_0034, 32'h0045_6000);
    add_row(K_REG, OP_XOR,  32'hAAAA_5555, 32'hFFFF_0000);
    add_row(K_REG, OP_SLL,  32'h8000_0001, 32'h0000_0021);  // Only low 5 bits count
    add_row(K_REG, OP_SRL,  32'h8000_0000, 32'd31);
    add_row(K_REG, OP_SRA,  32'h8000_0000, 32'd4);
    add_row(K_REG, OP_SLT,  32'hFFFF_FFFF, 32'd1);
    add_row(K_REG, OP_SLTU, 32'hFFFF_FFFF, 32'd1);
    add_row(K_IMM, OP_ADD,  32'd100,       32'h0000_0FFF);
    add_row(K_IMM, OP_AND,  32'h1234_5678, 32'h0000_00F0);
    add_row(K_IMM, OP_OR,   32'h0000_0000, 32'h0000_0800);
    add_row(K_IMM, OP_XOR,  32'hFFFF_0000, 32'h0000_07FF);
    add_row(K_IMM, OP_SLL,  32'd1,         32'd31);
    add_row(K_IMM, OP_SRL,  32'hF000_0000, 32'd28);
    add_row(K_IMM, OP_SRA,  32'hF000_0000, 32'd28);
    add_row(K_IMM, OP_SLT,  32'hFFFF_FFFB, 32'h0000_0FFE);
    add_row(K_IMM, OP_SLTU, 32'd5,         32'h0000_0FFF);
    add_row(K_MEM, OP_ADD,  32'hDEAD_BEEF, 32'h0000_0100);
    add_row(K_MEM, OP_ADD,  32'h0000_0001, 32'h0000_0FF0);
    add_row(K_BEQ, OP_ADD,  32'h55,        32'h55);
    add_row(K_BEQ, OP_ADD,  32'd3,         32'd4);
    add_row(K_BNE, OP_ADD,  32'd3,         32'd4);
    add_row(K_BNE, OP_ADD,  32'd9,         32'd9);
    add_row(K_JAL, OP_ADD,  32'h1234_0000, 32'd0);
    for (n = 0; n < 12; n++) begin
      r_kind = $unsigned($random(seed)) % 5;
      r_op   = $unsigned($random(seed)) % 10;
      ra     = $random(seed);
      rb     = $random(seed);
      if (r_kind == K_IMM && r_op == OP_SUB)
        r_op = OP_ADD;  // No SUBI in RV32I
      if ((r_kind == K_BEQ || r_kind == K_BNE) && rb[0])
        rb = ra;
      add_row(r_kind, r_op, ra, rb);
    end
  endtask

  task automatic load_program();
    int k;
    for (k = 0; k < prog_len; k++) begin
      @(negedge clk);
      prog_we   = 1'b1;
      prog_addr = k[`IMEM_AWIDTH-1:0];
      prog_data = prog[k];
    end
    @(negedge clk);
    prog_we = 1'b0;
  endtask

  task automatic wait_csr_we(input int row);
    int   cnt;
    logic seen;
    cnt  = 0;
    seen = 1'b0;
    while (!seen && cnt < TIMEOUT) begin
      @(negedge clk);
      seen = csr_we;
      cnt++;
    end
    if (!seen) begin
      $display("Timeout: csr_we never came within %0d cycles in row %0d", TIMEOUT, row);
      $display("TEST FAIL");
      $fatal(1, "no csr write");
    end
  endtask

  task automatic wait_reset_release();
    int cnt;
    cnt = 0;
    while (!arst_n && cnt < TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (!arst_n) begin
      $display("Timeout: reset was never released");
      $display("TEST FAIL");
      $fatal(1, "reset stuck");
    end
  endtask

  task automatic run_row(input int idx);
    @(negedge clk);
    run = 1'b0;
    repeat (2) @(negedge clk);  // Let the last instructions drain
    assemble(row_kind[idx], row_op[idx], row_a[idx], row_b[idx]);
    load_program();
    run = 1'b1;
    wait_csr_we(idx);
    check_value($sformatf("row %0d kind %0d op %0d csr", idx, row_kind[idx], row_op[idx]),
                csr, row_exp[idx]);
  endtask

  initial begin
    int i;
    run       = 1'b0;
    prog_we   = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    seed      = 14;
    build_table();
    wait_reset_release();

    // Idle after reset
    for (i = 0; i < 4; i++) begin
      @(negedge clk);
      check_value("csr after reset", csr, 32'd0);
      check_value("csr_we while idle", {31'd0, csr_we}, 32'd0);
    end

    for (i = 0; i < num_rows; i++)
      run_row(i);

    @(negedge clk);
    run = 1'b0;
    check_value("assertion failures", DUT.u_execute.u_chk.fail_count, 32'd0);
    $display("TEST PASS");
    $finish;
  end

endmodule

// File: riscv_core.f
+incdir+source
source/riscv_pkg.sv
source/pipe_if.sv
source/fetch_stage.sv
source/register_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/riscv_core.sv
verification/tb_clock_gen.sv
verification/riscv_core_chk.sv
verification/riscv_core_tb.sv
